// ==== list.f ====
source/mem_cfg_pkg.sv
source/lsu_pkg.sv
source/fetch_port.sv
source/data_port.sv
source/byte_memory.sv
source/system_memory.sv
testbench/system_memory_tb.sv

// ==== run.sh ====
#!/bin/sh
# Builds the system_memory testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --top-module system_memory_tb -f list.f -o system_memory_sim; then
    echo "error: verilator build failed"
    exit 1
fi

output=$(./obj_dir/system_memory_sim 2>&1)
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
    echo "error: simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qF "Simulation finished: PASS"; then
    exit 0
else
    echo "error: pass message not found in simulation output"
    exit 1
fi

// ==== testbench/system_memory_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module system_memory_tb;

    localparam int MEMORY_SIZE    = 256;
    localparam int ADDR_W         = $clog2(MEMORY_SIZE);
    localparam int RANDOM_CYCLES  = 200;
    // several times the length of all tests together.
    localparam int TIMEOUT_CYCLES = 2000;

    logic                  clk_i;
    logic                  rst_n_i;
    logic                  fetch_i;
    logic                  invalidate_i;
    mem_cfg_pkg::addr_t    fetch_address_i;
    mem_cfg_pkg::word_t    fetch_instruction_o;
    logic                  fetch_valid_o;
    logic                  load_request_i;
    mem_cfg_pkg::addr_t    load_address_i;
    mem_cfg_pkg::word_t    load_data_o;
    logic                  load_valid_o;
    logic                  store_request_i;
    mem_cfg_pkg::addr_t    store_address_i;
    lsu_pkg::store_width_t store_width_i;
    mem_cfg_pkg::word_t    store_data_i;
    logic                  store_done_o;

    logic [7:0]  model_mem [MEMORY_SIZE];
    logic [31:0] rng_state;
    int          cycle_count;

    system_memory #(.MEMORY_SIZE (MEMORY_SIZE)) dut (.*);

    always #20 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation finished: FAIL");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    // ==================================================================
    // reference model and helpers
    // ==================================================================

    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // byte addresses wrap modulo the array size.
    function automatic logic [ADDR_W - 1:0] wrap_address(input mem_cfg_pkg::addr_t address,
                                                         input int offset);
        return ADDR_W'((address + 32'(offset)) % MEMORY_SIZE);
    endfunction

    function automatic mem_cfg_pkg::word_t model_word(input mem_cfg_pkg::addr_t address);
        mem_cfg_pkg::word_t value;
        for (int k = 0; k < 4; k++) begin
            value[8 * k +: 8] = model_mem[wrap_address(address, k)];
        end
        return value;
    endfunction

    function automatic void model_store(input mem_cfg_pkg::addr_t address,
                                        input lsu_pkg::store_width_t width,
                                        input mem_cfg_pkg::word_t data);
        int lane_count;
        case (width)
            lsu_pkg::BYTE:      lane_count = 1;
            lsu_pkg::HALF_WORD: lane_count = 2;
            lsu_pkg::WORD:      lane_count = 4;
            default:            lane_count = 0;
        endcase
        for (int k = 0; k < lane_count; k++) begin
            model_mem[wrap_address(address, k)] = data[8 * k +: 8];
        end
    endfunction

    task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                         input string what);
        if (actual !== expected) begin
            $display("Mismatch at %0t ns: %s, got %h, expected %h",
                     $time, what, actual, expected);
            $display("Simulation finished: FAIL");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    // each request helper checks the response in the cycle after the request.
    task automatic issue_store(input mem_cfg_pkg::addr_t address,
                               input lsu_pkg::store_width_t width,
                               input mem_cfg_pkg::word_t data);
        @(posedge clk_i);
        store_request_i <= 1'b1;
        store_address_i <= address;
        store_width_i   <= width;
        store_data_i    <= data;
        @(posedge clk_i);
        store_request_i <= 1'b0;
        model_store(address, width, data);
        @(negedge clk_i);
        check(32'(store_done_o), 32'd1, "store done");
    endtask

    task automatic issue_load(input mem_cfg_pkg::addr_t address);
        mem_cfg_pkg::word_t expected;
        @(posedge clk_i);
        load_request_i <= 1'b1;
        load_address_i <= address;
        @(posedge clk_i);
        load_request_i <= 1'b0;
        expected = model_word(address & ~32'h3);
        @(negedge clk_i);
        check(32'(load_valid_o), 32'd1, "load valid");
        check(load_data_o, expected, "load data");
    endtask

    task automatic issue_fetch(input mem_cfg_pkg::addr_t address, input logic flush);
        @(posedge clk_i);
        fetch_i         <= 1'b1;
        fetch_address_i <= address;
        @(posedge clk_i);
        fetch_i      <= 1'b0;
        invalidate_i <= flush;
        @(negedge clk_i);
        check(32'(fetch_valid_o), 32'(!flush), "fetch valid");
        check(fetch_instruction_o, model_word(address & ~32'h1), "fetch instruction");
        @(posedge clk_i);
        invalidate_i <= 1'b0;
    endtask

    // ==================================================================
    // directed tests
    // ==================================================================

    task automatic test_reset_state();
        @(negedge clk_i);
        check(32'(fetch_valid_o), 32'd0, "fetch valid after reset");
        check(32'(load_valid_o), 32'd0, "load valid after reset");
        check(32'(store_done_o), 32'd0, "store done after reset");
        check(fetch_instruction_o, 32'd0, "instruction after reset");
        check(load_data_o, 32'd0, "load data after reset");
        issue_load(32'h40);
        issue_load(next_random());
    endtask

    task automatic test_word_store_load();
        mem_cfg_pkg::word_t data;
        data = next_random();
        @(posedge clk_i);
        store_request_i <= 1'b1;
        store_address_i <= 32'h10;
        store_width_i   <= lsu_pkg::WORD;
        store_data_i    <= data;
        @(posedge clk_i);
        // load right behind the store.
        store_request_i <= 1'b0;
        load_request_i  <= 1'b1;
        load_address_i  <= 32'h10;
        model_store(32'h10, lsu_pkg::WORD, data);
        @(negedge clk_i);
        check(32'(store_done_o), 32'd1, "word store done");
        @(posedge clk_i);
        load_request_i <= 1'b0;
        @(negedge clk_i);
        check(32'(store_done_o), 32'd0, "store done is a single pulse");
        check(32'(load_valid_o), 32'd1, "load valid after store");
        check(load_data_o, data, "load data after store");
        issue_load(32'h13);
    endtask

    task automatic test_sub_word_stores();
        for (int offset = 0; offset < 4; offset++) begin
            issue_store(32'h20 + 32'(offset), lsu_pkg::BYTE, next_random());
            issue_load(32'h20);
            issue_store(32'h30 + 32'(offset), lsu_pkg::HALF_WORD, next_random());
            issue_load(32'h30);
            issue_load(32'h34);
        end
        // stores at the top of the array wrap to address 0.
        issue_store(32'hff, lsu_pkg::HALF_WORD, next_random());
        issue_load(32'hfc);
        issue_load(32'h00);
        issue_store(32'hfe, lsu_pkg::WORD, next_random());
        issue_load(32'hfc);
        issue_load(32'h00);
    endtask

    task automatic test_fetch();
        issue_fetch(32'h10, 1'b0);
        issue_fetch(32'h12, 1'b0);
        issue_fetch(32'h31, 1'b0);
        issue_fetch(32'hfe, 1'b0);
    endtask

    task automatic test_invalidate();
        issue_fetch(32'h22, 1'b1);
        issue_fetch(32'h22, 1'b0);
    endtask

    // one request set per cycle, checked one cycle later.
    task automatic test_random_traffic();
        logic                  st_req;
        logic                  ld_req;
        logic                  fe_req;
        logic                  prev_st;
        logic                  prev_ld;
        logic                  prev_fe;
        logic [31:0]           bits;
        mem_cfg_pkg::addr_t    st_addr;
        mem_cfg_pkg::addr_t    ld_addr;
        mem_cfg_pkg::addr_t    fe_addr;
        lsu_pkg::store_width_t st_width;
        mem_cfg_pkg::word_t    st_data;
        mem_cfg_pkg::word_t    exp_load;
        mem_cfg_pkg::word_t    exp_fetch;

        prev_st   = 1'b0;
        prev_ld   = 1'b0;
        prev_fe   = 1'b0;
        exp_load  = '0;
        exp_fetch = '0;
        st_addr   = '0;
        st_width  = lsu_pkg::BYTE;
        st_data   = '0;
        for (int i = 0; i <= RANDOM_CYCLES; i++) begin
            @(posedge clk_i);
            // the edge just passed wrote last cycle's store.
            if (prev_st) begin
                model_store(st_addr, st_width, st_data);
            end
            bits     = next_random();
            st_req   = (i < RANDOM_CYCLES) && bits[0];
            ld_req   = (i < RANDOM_CYCLES) && bits[1];
            fe_req   = (i < RANDOM_CYCLES) && bits[2];
            st_addr  = next_random();
            st_width = lsu_pkg::store_width_t'(2'(next_random() % 3));
            st_data  = next_random();
            ld_addr  = next_random();
            fe_addr  = next_random();
            store_request_i <= st_req;
            store_address_i <= st_addr;
            store_width_i   <= st_width;
            store_data_i    <= st_data;
            load_request_i  <= ld_req;
            load_address_i  <= ld_addr;
            fetch_i         <= fe_req;
            fetch_address_i <= fe_addr;
            @(negedge clk_i);
            if (i > 0) begin
                check(32'(store_done_o), 32'(prev_st), "random store done");
                check(32'(load_valid_o), 32'(prev_ld), "random load valid");
                check(32'(fetch_valid_o), 32'(prev_fe), "random fetch valid");
                check(load_data_o, exp_load, "random load data");
                check(fetch_instruction_o, exp_fetch, "random fetch instruction");
            end
            // reads see the array as it stands before this cycle's store.
            exp_load  = model_word(ld_addr & ~32'h3);
            exp_fetch = model_word(fe_addr & ~32'h1);
            prev_st   = st_req;
            prev_ld   = ld_req;
            prev_fe   = fe_req;
        end
    endtask

    initial begin
        clk_i           = 1'b0;
        rst_n_i         = 1'b0;
        // requests held through reset must not show up as strobes afterwards.
        fetch_i         = 1'b1;
        invalidate_i    = 1'b0;
        fetch_address_i = '0;
        load_request_i  = 1'b1;
        load_address_i  = '0;
        store_request_i = 1'b1;
        store_address_i = '0;
        store_width_i   = lsu_pkg::BYTE;
        store_data_i    = '0;
        cycle_count     = 0;
        rng_state       = 32'hc9957fc8;
        for (int i = 0; i < MEMORY_SIZE; i++) begin
            model_mem[ADDR_W'(i)] = 8'h00;
        end

        repeat (10) @(posedge clk_i);
        rst_n_i         <= 1'b1;
        fetch_i         <= 1'b0;
        load_request_i  <= 1'b0;
        store_request_i <= 1'b0;

        test_reset_state();
        test_word_store_load();
        test_sub_word_stores();
        test_fetch();
        test_invalidate();
        test_random_traffic();

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule : system_memory_tb

`default_nettype wire

// ==== source/system_memory.sv ====
`timescale 1ns/10ps
`default_nettype none

module system_memory #(
    parameter int MEMORY_SIZE = 256
) (
    input  logic                    clk_i,
    input  logic                    rst_n_i,

    // instruction channel.
    input  logic                    fetch_i,
    input  logic                    invalidate_i,
    input  mem_cfg_pkg::addr_t      fetch_address_i,
    output mem_cfg_pkg::word_t      fetch_instruction_o,
    output logic                    fetch_valid_o,

    // load channel.
    input  logic                    load_request_i,
    input  mem_cfg_pkg::addr_t      load_address_i,
    output mem_cfg_pkg::word_t      load_data_o,
    output logic                    load_valid_o,

    // store channel.
    input  logic                    store_request_i,
    input  mem_cfg_pkg::addr_t      store_address_i,
    input  lsu_pkg::store_width_t   store_width_i,
    input  mem_cfg_pkg::word_t      store_data_i,
    output logic                    store_done_o
);

    localparam int ADDR_W = $clog2(MEMORY_SIZE);

    logic [ADDR_W - 1:0]   fetch_rd_address;
    mem_cfg_pkg::word_t    fetch_rd_data;
    logic [ADDR_W - 1:0]   load_rd_address;
    mem_cfg_pkg::word_t    load_rd_data;
    logic [ADDR_W - 1:0]   wr_address;
    mem_cfg_pkg::byte_en_t wr_enable;
    mem_cfg_pkg::word_t    wr_data;

    // ==================================================================
    // request ports
    // ==================================================================

    fetch_port #(
        .MEMORY_SIZE (MEMORY_SIZE)
    ) u_fetch_port (
        .clk_i               (clk_i),
        .rst_n_i             (rst_n_i),
        .fetch_i             (fetch_i),
        .invalidate_i        (invalidate_i),
        .fetch_address_i     (fetch_address_i),
        .rd_address_o        (fetch_rd_address),
        .rd_data_i           (fetch_rd_data),
        .fetch_instruction_o (fetch_instruction_o),
        .fetch_valid_o       (fetch_valid_o)
    );

    data_port #(
        .MEMORY_SIZE (MEMORY_SIZE)
    ) u_data_port (
        .clk_i             (clk_i),
        .rst_n_i           (rst_n_i),
        .load_request_i    (load_request_i),
        .load_address_i    (load_address_i),
        .load_rd_address_o (load_rd_address),
        .load_rd_data_i    (load_rd_data),
        .load_data_o       (load_data_o),
        .load_valid_o      (load_valid_o),
        .store_request_i   (store_request_i),
        .store_address_i   (store_address_i),
        .store_width_i     (store_width_i),
        .store_data_i      (store_data_i),
        .wr_address_o      (wr_address),
        .wr_enable_o       (wr_enable),
        .wr_data_o         (wr_data),
        .store_done_o      (store_done_o)
    );

    // fetch and load share one array and never collide.
    byte_memory #(
        .MEMORY_SIZE (MEMORY_SIZE)
    ) u_byte_memory (
        .clk_i              (clk_i),
        .fetch_rd_address_i (fetch_rd_address),
        .fetch_rd_data_o    (fetch_rd_data),
        .load_rd_address_i  (load_rd_address),
        .load_rd_data_o     (load_rd_data),
        .wr_address_i       (wr_address),
        .wr_enable_i        (wr_enable),
        .wr_data_i          (wr_data)
    );

endmodule : system_memory

`default_nettype wire

// ==== source/byte_memory.sv ====
`timescale 1ns/10ps
`default_nettype none

module byte_memory #(
    parameter int MEMORY_SIZE = 256
) (
    input  logic                                clk_i,

    // read ports, combinational.
    input  logic [$clog2(MEMORY_SIZE) - 1:0]    fetch_rd_address_i,
    output mem_cfg_pkg::word_t                  fetch_rd_data_o,
    input  logic [$clog2(MEMORY_SIZE) - 1:0]    load_rd_address_i,
    output mem_cfg_pkg::word_t                  load_rd_data_o,

    // byte lane write port.
    input  logic [$clog2(MEMORY_SIZE) - 1:0]    wr_address_i,
    input  mem_cfg_pkg::byte_en_t               wr_enable_i,
    input  mem_cfg_pkg::word_t                  wr_data_i
);

    localparam int ADDR_W = $clog2(MEMORY_SIZE);

    logic [7:0]          mem [MEMORY_SIZE];
    logic [ADDR_W - 1:0] wr_lane_address [lsu_pkg::LANES];

    // simulation memory starts cleared.
    initial begin
        for (int i = 0; i < MEMORY_SIZE; i++) begin
            mem[i] = 8'h00;
        end
    end

    // ==================================================================
    // per-lane address generation
    // ==================================================================

    // lane k sits at base + k; the truncated sum wraps at the array end.
    for (genvar k = 0; k < lsu_pkg::LANES; k++) begin : g_lane
        logic [ADDR_W - 1:0] fetch_lane_address;
        logic [ADDR_W - 1:0] load_lane_address;

        assign fetch_lane_address = fetch_rd_address_i + ADDR_W'(k);
        assign load_lane_address  = load_rd_address_i + ADDR_W'(k);
        assign wr_lane_address[k] = wr_address_i + ADDR_W'(k);

        // little-endian, lowest address in the low byte.
        assign fetch_rd_data_o[8 * k +: 8] = mem[fetch_lane_address];
        assign load_rd_data_o[8 * k +: 8]  = mem[load_lane_address];
    end

    // ==================================================================
    // write port
    // ==================================================================

    always_ff @(posedge clk_i) begin
        for (int k = 0; k < lsu_pkg::LANES; k++) begin
            if (wr_enable_i[k]) begin
                mem[wr_lane_address[k]] <= wr_data_i[8 * k +: 8];
            end
        end
    end

endmodule : byte_memory

`default_nettype wire

// ==== source/data_port.sv ====
`timescale 1ns/10ps
`default_nettype none

module data_port #(
    parameter int MEMORY_SIZE = 256
) (
    input  logic                                clk_i,
    input  logic                                rst_n_i,

    // load channel.
    input  logic                                load_request_i,
    input  mem_cfg_pkg::addr_t                  load_address_i,
    output logic [$clog2(MEMORY_SIZE) - 1:0]    load_rd_address_o,
    input  mem_cfg_pkg::word_t                  load_rd_data_i,
    output mem_cfg_pkg::word_t                  load_data_o,
    output logic                                load_valid_o,

    // store channel.
    input  logic                                store_request_i,
    input  mem_cfg_pkg::addr_t                  store_address_i,
    input  lsu_pkg::store_width_t               store_width_i,
    input  mem_cfg_pkg::word_t                  store_data_i,
    output logic [$clog2(MEMORY_SIZE) - 1:0]    wr_address_o,
    output mem_cfg_pkg::byte_en_t               wr_enable_o,
    output mem_cfg_pkg::word_t                  wr_data_o,
    output logic                                store_done_o
);

    localparam int ADDR_W = $clog2(MEMORY_SIZE);

    // ==================================================================
    // load path
    // ==================================================================

    // loads always read the whole word holding the address.
    assign load_rd_address_o = {load_address_i[ADDR_W - 1:2], 2'b00};

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            load_data_o  <= '0;
            load_valid_o <= 1'b0;
        end else begin
            load_data_o  <= load_rd_data_i;
            load_valid_o <= load_request_i;
        end
    end

    // ==================================================================
    // store path
    // ==================================================================

    // stores may start at any byte; the array wraps the lanes itself.
    assign wr_address_o = store_address_i[ADDR_W - 1:0];
    assign wr_data_o    = store_data_i;

    // enable the low lanes, as many as the width covers.
    always_comb begin
        int lane_count;

        case (store_width_i)
            lsu_pkg::BYTE:      lane_count = 1;
            lsu_pkg::HALF_WORD: lane_count = 2;
            lsu_pkg::WORD:      lane_count = lsu_pkg::LANES;
            default:            lane_count = 0;
        endcase

        for (int k = 0; k < lsu_pkg::LANES; k++) begin
            wr_enable_o[k] = store_request_i && (k < lane_count);
        end
    end

    // the write lands at the request edge and done follows one cycle later.
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            store_done_o <= 1'b0;
        end else begin
            store_done_o <= store_request_i;
        end
    end

endmodule : data_port

`default_nettype wire

// ==== source/fetch_port.sv ====
`timescale 1ns/10ps
`default_nettype none

module fetch_port #(
    parameter int MEMORY_SIZE = 256
) (
    input  logic                                clk_i,
    input  logic                                rst_n_i,

    // instruction fetch request.
    input  logic                                fetch_i,
    input  logic                                invalidate_i,
    input  mem_cfg_pkg::addr_t                  fetch_address_i,

    // read port of the byte array.
    output logic [$clog2(MEMORY_SIZE) - 1:0]    rd_address_o,
    input  mem_cfg_pkg::word_t                  rd_data_i,

    // fetched instruction.
    output mem_cfg_pkg::word_t                  fetch_instruction_o,
    output logic                                fetch_valid_o
);

    localparam int ADDR_W = $clog2(MEMORY_SIZE);

    logic fetch_pending;

    // halfword aligned so compressed instructions can start at any even byte.
    assign rd_address_o = {fetch_address_i[ADDR_W - 1:1], 1'b0};

    // the instruction register follows the array every cycle.
    // only the valid flag tells the core the word was requested.
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            fetch_instruction_o <= '0;
            fetch_pending       <= 1'b0;
        end else begin
            fetch_instruction_o <= rd_data_i;
            fetch_pending       <= fetch_i;
        end
    end

    // a flush in the response cycle drops the fetched word.
    assign fetch_valid_o = fetch_pending & ~invalidate_i;

endmodule : fetch_port

`default_nettype wire

// ==== source/lsu_pkg.sv ====
`default_nettype none

// ======================================================================
// load/store unit definitions
// ======================================================================

package lsu_pkg;

    // size of a store, as encoded by the core.
    typedef enum logic [1:0] {
        BYTE      = 2'b00,
        HALF_WORD = 2'b01,
        WORD      = 2'b10
    } store_width_t;

    // byte lanes per word.
    localparam int LANES = 4;

endpackage : lsu_pkg

`default_nettype wire

// ==== source/mem_cfg_pkg.sv ====
`default_nettype none

// ======================================================================
// memory data and address types
// ======================================================================

package mem_cfg_pkg;

    // one 32-bit word, little-endian in memory.
    typedef logic [31:0] word_t;

    // full byte address as the core sends it.
    typedef logic [31:0] addr_t;

    // one write enable per byte lane of a word.
    typedef logic [3:0] byte_en_t;

endpackage : mem_cfg_pkg

`default_nettype wire
